// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS  = 2;
    localparam int NUM_SETS  = 256;
    localparam int NUM_BANKS = 4;

    typedef logic [7:0]  index_t;    // set index, addr[11:4]
    typedef logic [19:0] tag_t;      // physical tag, addr[31:12]
    typedef logic [3:0]  offset_t;   // byte offset, [3:2] picks the bank
    typedef logic [1:0]  bank_sel_t; // word number within a line
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [20:0] tagv_t;     // {tag, valid}
    typedef logic [1:0]  way_hit_t;  // one flag per way
    typedef logic [2:0]  bus_type_t;

    // read bus request types
    localparam bus_type_t BUS_TYPE_WORD = 3'b010;
    localparam bus_type_t BUS_TYPE_LINE = 3'b100;

    // any nonzero value works for the lfsr
    localparam logic [15:0] LFSR_SEED = 16'hace1;

    typedef enum logic [1:0] {
        MAIN_IDLE,
        MAIN_LOOKUP,
        MAIN_REPLACE,
        MAIN_REFILL
    } main_state_t;

endpackage

`default_nettype wire

// File: rtl/icache_sram.sv
`default_nettype none

module icache_sram #(
    parameter int data_width = 32,
    parameter int depth_log2 = 8
) (
    input  wire logic                  clk,
    input  wire logic                  en,
    input  wire logic                  we,
    input  wire logic [depth_log2-1:0] addr,
    input  wire logic [data_width-1:0] wdata,
    output logic      [data_width-1:0] rdata
);

    logic [data_width-1:0] mem [0:(1 << depth_log2) - 1];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr]; // read-first, old word on a write
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_lfsr.sv
`default_nettype none

module icache_lfsr import icache_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    output logic      random_bit
);

    logic [15:0] lfsr;
    logic        feedback;

    // taps 16,14,13,11 give a maximal length sequence
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    assign random_bit = lfsr[0];

endmodule

`default_nettype wire

// File: rtl/icache_tag_array.sv
`default_nettype none

module icache_tag_array import icache_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire index_t array_index,
    input  wire logic   tag_en,
    input  wire tag_t   lookup_tag,
    input  wire logic   fill_tag_we,
    input  wire logic   fill_way,
    input  wire tag_t   fill_tag,
    output way_hit_t    way_hit,
    output logic        victim_way
);

    tagv_t tagv_rd [NUM_WAYS];
    tagv_t tagv_wdata;
    logic  random_bit;

    assign tagv_wdata = {fill_tag, 1'b1}; // fills always set valid

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic way_we;

        assign way_we = fill_tag_we && (fill_way == w[0]);

        icache_sram #(
            .data_width ($bits(tagv_t)),
            .depth_log2 ($clog2(NUM_SETS))
        ) u_tagv (
            .clk   (clk),
            .en    (tag_en),
            .we    (way_we),
            .addr  (array_index),
            .wdata (tagv_wdata),
            .rdata (tagv_rd[w])
        );

        // valid and tag match
        assign way_hit[w] = tagv_rd[w][0] && (tagv_rd[w][20:1] == lookup_tag);
    end

    icache_lfsr u_lfsr (
        .clk        (clk),
        .reset      (reset),
        .random_bit (random_bit)
    );

    // an empty way first, random only when the set is full
    always_comb begin
        if (!tagv_rd[0][0]) begin
            victim_way = 1'b0;
        end else if (!tagv_rd[1][0]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = random_bit;
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_data_array.sv
`default_nettype none

module icache_data_array import icache_pkg::*; (
    input  wire logic      clk,
    input  wire index_t    array_index,
    input  wire logic      data_en,
    input  wire logic      fill_we,
    input  wire logic      fill_way,
    input  wire bank_sel_t fill_bank,
    input  wire word_t     fill_word,
    input  wire bank_sel_t read_bank,
    input  wire way_hit_t  way_hit,
    output word_t          hit_word
);

    word_t bank_rd  [NUM_WAYS][NUM_BANKS];
    word_t way_word [NUM_WAYS];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
            logic bank_we;

            // one bank of one way per beat
            assign bank_we = fill_we && (fill_way == w[0]) && (fill_bank == b[1:0]);

            icache_sram #(
                .data_width ($bits(word_t)),
                .depth_log2 ($clog2(NUM_SETS))
            ) u_bank (
                .clk   (clk),
                .en    (data_en),
                .we    (bank_we),
                .addr  (array_index),
                .wdata (fill_word),
                .rdata (bank_rd[w][b])
            );
        end

        assign way_word[w] = bank_rd[w][read_bank];
    end

    // at most one way hits, so and-or is a mux
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_word = hit_word | ({$bits(word_t){way_hit[w]}} & way_word[w]);
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_ctrl.sv
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    // cpu fetch port
    input  wire logic      valid,
    input  wire index_t    index,
    input  wire offset_t   offset,
    input  wire tag_t      tag,         // one cycle after index
    input  wire logic      uncache_en,  // same cycle as tag
    output logic           addr_ok,
    output logic           data_ok,
    output word_t          rdata,
    output logic           cache_miss,
    // read bus
    output logic           rd_req,
    output bus_type_t      rd_type,
    output addr_t          rd_addr,
    input  wire logic      rd_rdy,
    input  wire logic      ret_valid,
    input  wire logic      ret_last,
    input  wire word_t     ret_data,
    // tag and data arrays
    output index_t         array_index,
    output logic           tag_en,
    output logic           data_en,
    output tag_t           lookup_tag,
    output logic           fill_tag_we,
    output logic           fill_we,
    output logic           fill_way,
    output bank_sel_t      fill_bank,
    output word_t          fill_word,
    output bank_sel_t      read_bank,
    output tag_t           fill_tag,
    input  wire way_hit_t  way_hit,
    input  wire logic      victim_way,
    input  wire word_t     hit_word
);

    main_state_t state;

    // request buffer
    index_t  req_index;
    offset_t req_offset;
    tag_t    req_tag;
    logic    req_uncached;

    // miss buffer
    logic      miss_way;
    bank_sel_t ret_num;     // beats returned so far

    logic st_idle;
    logic st_lookup;
    logic st_replace;
    logic st_refill;
    logic cache_hit;
    logic accept;
    logic ret_beat;

    assign st_idle    = (state == MAIN_IDLE);
    assign st_lookup  = (state == MAIN_LOOKUP);
    assign st_replace = (state == MAIN_REPLACE);
    assign st_refill  = (state == MAIN_REFILL);

    assign cache_hit = (|way_hit) && !uncache_en; // uncached always takes the miss path
    assign addr_ok   = st_idle || (st_lookup && cache_hit);
    assign accept    = valid && addr_ok;
    assign ret_beat  = st_refill && ret_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= MAIN_IDLE;
            req_uncached <= 1'b0;
        end else begin
            case (state)
                MAIN_IDLE: begin
                    if (accept) begin
                        state <= MAIN_LOOKUP;
                    end
                end
                MAIN_LOOKUP: begin
                    if (!cache_hit) begin
                        state        <= MAIN_REPLACE;
                        req_uncached <= uncache_en;
                    end else if (!valid) begin
                        state <= MAIN_IDLE;
                    end
                end
                MAIN_REPLACE: begin
                    if (rd_rdy) begin
                        state <= MAIN_REFILL;
                    end
                end
                MAIN_REFILL: begin
                    if (ret_valid && ret_last) begin
                        state <= MAIN_IDLE;
                    end
                end
                default: begin
                    state <= MAIN_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_index  <= index;
            req_offset <= offset;
        end
        if (st_lookup && !cache_hit) begin
            req_tag  <= tag;
            miss_way <= victim_way; // tag ram output still for this index
        end
        if (st_replace && rd_rdy) begin
            ret_num <= '0;
        end else if (ret_beat) begin
            ret_num <= ret_num + 1'b1;
        end
    end

    // read bus, held until rd_rdy
    assign rd_req  = st_replace;
    assign rd_type = req_uncached ? BUS_TYPE_WORD : BUS_TYPE_LINE;
    assign rd_addr = req_uncached ? {req_tag, req_index, req_offset}
                                  : {req_tag, req_index, 4'b0000};

    // hit answer or the critical word straight off the bus
    assign data_ok = (st_lookup && cache_hit)
                   || (ret_beat && (req_uncached || ret_num == req_offset[3:2]));
    assign rdata   = st_lookup ? hit_word : ret_data;

    assign cache_miss = ret_beat && ret_last && !req_uncached;

    // arrays idle during uncached misses
    assign array_index = addr_ok ? index : req_index;
    assign tag_en      = st_idle || st_lookup || !req_uncached;
    assign data_en     = tag_en;
    assign lookup_tag  = tag;
    assign read_bank   = req_offset[3:2];

    assign fill_we     = ret_beat && !req_uncached;
    assign fill_tag_we = fill_we && ret_last; // line goes valid with the last word
    assign fill_way    = miss_way;
    assign fill_bank   = ret_num;
    assign fill_word   = ret_data;
    assign fill_tag    = req_tag;

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`default_nettype none

module icache_top import icache_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    // cpu fetch port
    input  wire logic      valid,
    input  wire index_t    index,
    input  wire offset_t   offset,
    input  wire tag_t      tag,
    input  wire logic      uncache_en,
    output logic           addr_ok,
    output logic           data_ok,
    output word_t          rdata,
    output logic           cache_miss,
    // read bus
    output logic           rd_req,
    output bus_type_t      rd_type,
    output addr_t          rd_addr,
    input  wire logic      rd_rdy,
    input  wire logic      ret_valid,
    input  wire logic      ret_last,
    input  wire word_t     ret_data
);

    index_t    array_index;
    logic      tag_en;
    logic      data_en;
    tag_t      lookup_tag;
    logic      fill_tag_we;
    logic      fill_we;
    logic      fill_way;
    bank_sel_t fill_bank;
    word_t     fill_word;
    bank_sel_t read_bank;
    tag_t      fill_tag;
    way_hit_t  way_hit;
    logic      victim_way;
    word_t     hit_word;

    icache_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .index       (index),
        .offset      (offset),
        .tag         (tag),
        .uncache_en  (uncache_en),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .cache_miss  (cache_miss),
        .rd_req      (rd_req),
        .rd_type     (rd_type),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .array_index (array_index),
        .tag_en      (tag_en),
        .data_en     (data_en),
        .lookup_tag  (lookup_tag),
        .fill_tag_we (fill_tag_we),
        .fill_we     (fill_we),
        .fill_way    (fill_way),
        .fill_bank   (fill_bank),
        .fill_word   (fill_word),
        .read_bank   (read_bank),
        .fill_tag    (fill_tag),
        .way_hit     (way_hit),
        .victim_way  (victim_way),
        .hit_word    (hit_word)
    );

    icache_tag_array u_tag_array (
        .clk         (clk),
        .reset       (reset),
        .array_index (array_index),
        .tag_en      (tag_en),
        .lookup_tag  (lookup_tag),
        .fill_tag_we (fill_tag_we),
        .fill_way    (fill_way),
        .fill_tag    (fill_tag),
        .way_hit     (way_hit),
        .victim_way  (victim_way)
    );

    icache_data_array u_data_array (
        .clk         (clk),
        .array_index (array_index),
        .data_en     (data_en),
        .fill_we     (fill_we),
        .fill_way    (fill_way),
        .fill_bank   (fill_bank),
        .fill_word   (fill_word),
        .read_bank   (read_bank),
        .way_hit     (way_hit),
        .hit_word    (hit_word)
    );

endmodule

`default_nettype wire

// File: sim/icache_tb.sv
`default_nettype none

module icache_tb import icache_pkg::*; ();

    localparam int          NUM_TESTS    = 15;
    localparam int          RESET_CYCLES = 3;
    localparam int          CYCLE_LIMIT  = NUM_TESTS * 20 + RESET_CYCLES;
    localparam logic [31:0] SEED         = 32'h717873cf;

    // responder phases
    localparam int PH_IDLE  = 0;
    localparam int PH_WAIT  = 1;
    localparam int PH_BEATS = 2;

    logic      clk;
    logic      reset;
    logic      valid;
    index_t    index;
    offset_t   offset;
    tag_t      tag;
    logic      uncache_en;
    logic      addr_ok;
    logic      data_ok;
    word_t     rdata;
    logic      cache_miss;
    logic      rd_req;
    bus_type_t rd_type;
    addr_t     rd_addr;
    logic      rd_rdy;
    logic      ret_valid;
    logic      ret_last;
    word_t     ret_data;

    // request table, one column per array
    string     t_name   [NUM_TESTS];
    index_t    t_index  [NUM_TESTS];
    offset_t   t_offset [NUM_TESTS];
    tag_t      t_tag    [NUM_TESTS];
    logic      t_unc    [NUM_TESTS];
    logic      t_req    [NUM_TESTS];  // bus request expected
    bus_type_t t_type   [NUM_TESTS];
    int        num_loaded;

    icache_top dut (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .index      (index),
        .offset     (offset),
        .tag        (tag),
        .uncache_en (uncache_en),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .cache_miss (cache_miss),
        .rd_req     (rd_req),
        .rd_type    (rd_type),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // backing memory, a pure function of the byte address
    function automatic word_t mem_word(input addr_t a);
        return xorshift32(a ^ SEED);
    endfunction

    function automatic addr_t word_addr(input int e);
        return {t_tag[e], t_index[e], t_offset[e][3:2], 2'b00};
    endfunction

    function automatic addr_t req_addr(input int e);
        return t_unc[e] ? {t_tag[e], t_index[e], t_offset[e]}
                        : {t_tag[e], t_index[e], 4'b0000};
    endfunction

    task automatic add_entry(input string name, input index_t idx, input offset_t off,
                             input tag_t tg, input logic unc, input logic req,
                             input bus_type_t typ);
        t_name[num_loaded]   = name;
        t_index[num_loaded]  = idx;
        t_offset[num_loaded] = off;
        t_tag[num_loaded]    = tg;
        t_unc[num_loaded]    = unc;
        t_req[num_loaded]    = req;
        t_type[num_loaded]   = typ;
        num_loaded++;
    endtask

    task automatic load_table();
        num_loaded = 0;
        add_entry("cold_line",           8'h10, 4'h4, 20'h12345, 1'b0, 1'b1, BUS_TYPE_LINE);
        add_entry("same_line_w2",        8'h10, 4'h8, 20'h12345, 1'b0, 1'b0, BUS_TYPE_LINE);
        add_entry("same_line_w3",        8'h10, 4'hc, 20'h12345, 1'b0, 1'b0, BUS_TYPE_LINE);
        add_entry("same_line_w0",        8'h10, 4'h0, 20'h12345, 1'b0, 1'b0, BUS_TYPE_LINE);
        add_entry("fill_first_way",      8'h2a, 4'hc, 20'h0aaaa, 1'b0, 1'b1, BUS_TYPE_LINE);
        add_entry("fill_second_way",     8'h2a, 4'h0, 20'h0bbbb, 1'b0, 1'b1, BUS_TYPE_LINE);
        add_entry("reread_first",        8'h2a, 4'h4, 20'h0aaaa, 1'b0, 1'b0, BUS_TYPE_LINE);
        add_entry("reread_second",       8'h2a, 4'h8, 20'h0bbbb, 1'b0, 1'b0, BUS_TYPE_LINE);
        add_entry("uncached_read",       8'h33, 4'h8, 20'hbfc00, 1'b1, 1'b1, BUS_TYPE_WORD);
        add_entry("uncached_repeat",     8'h33, 4'h8, 20'hbfc00, 1'b1, 1'b1, BUS_TYPE_WORD);
        add_entry("uncached_over_line",  8'h10, 4'hc, 20'h12345, 1'b1, 1'b1, BUS_TYPE_WORD);
        add_entry("line_after_uncached", 8'h10, 4'hc, 20'h12345, 1'b0, 1'b0, BUS_TYPE_LINE);
        add_entry("third_tag_miss",      8'h2a, 4'h4, 20'h0cccc, 1'b0, 1'b1, BUS_TYPE_LINE);
        add_entry("third_tag_hit",       8'h2a, 4'hc, 20'h0cccc, 1'b0, 1'b0, BUS_TYPE_LINE);
        add_entry("other_set_kept",      8'h10, 4'h4, 20'h12345, 1'b0, 1'b0, BUS_TYPE_LINE);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_type(input string name, input bus_type_t expected,
                              input bus_type_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_bus_count(input int e, input int count);
        check_flag({t_name[e], " rd_req"}, t_req[e], count > 0);
        if (count > 1) begin
            fail_run($sformatf("%s issued %0d read bus requests instead of one", t_name[e], count));
        end
    endtask

    initial begin : run
        int          cycle;
        int          next_entry;
        int          last_acc;
        int          acc_cycle;
        int          pend_entry;
        logic        pend_valid;
        int          bus_reqs;
        int          reqs_at_acc;
        int          bus_phase;
        int          rdy_wait;
        int          gap;
        int          beat_idx;
        int          beat_total;
        logic        beat_line;
        addr_t       beat_base;
        logic [31:0] rng;
        int          tail;
        logic        accept;
        string       cur;

        load_table();
        reset       = 1'b1;
        valid       = 1'b0;
        index       = '0;
        offset      = '0;
        tag         = '0;
        uncache_en  = 1'b0;
        rd_rdy      = 1'b0;
        ret_valid   = 1'b0;
        ret_last    = 1'b0;
        ret_data    = '0;
        rng         = SEED;
        cycle       = 0;
        next_entry  = 0;
        last_acc    = -1;
        acc_cycle   = 0;
        pend_entry  = 0;
        pend_valid  = 1'b0;
        bus_reqs    = 0;
        reqs_at_acc = 0;
        bus_phase   = PH_IDLE;
        rdy_wait    = 0;
        gap         = 0;
        beat_idx    = 0;
        beat_total  = 0;
        beat_line   = 1'b0;
        beat_base   = '0;
        tail        = 0;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_flag("after_reset addr_ok", 1'b1, addr_ok);
        check_flag("after_reset rd_req", 1'b0, rd_req);
        check_flag("after_reset data_ok", 1'b0, data_ok);
        check_flag("after_reset cache_miss", 1'b0, cache_miss);
        @(posedge clk);
        reset  <= 1'b0;
        valid  <= 1'b1;
        index  <= t_index[0];
        offset <= t_offset[0];

        while (tail < 2) begin
            @(negedge clk); // outputs settled for this cycle
            cycle++;
            if (cycle > CYCLE_LIMIT) begin
                fail_run("timeout, the cache stopped answering requests");
            end
            cur = (last_acc >= 0) ? t_name[last_acc] : "start";

            // cache_miss only on the last beat of a line fill
            check_flag({cur, " cache_miss"}, ret_valid && ret_last && beat_line, cache_miss);

            if (pend_valid && !t_req[pend_entry] && cycle == acc_cycle + 1) begin
                check_flag({t_name[pend_entry], " hit data_ok"}, 1'b1, data_ok);
            end
            if (data_ok) begin
                if (!pend_valid) begin
                    fail_run("data_ok came with no request outstanding");
                end
                if (t_req[pend_entry]) begin
                    check_flag({t_name[pend_entry], " critical beat"}, 1'b1, ret_valid &&
                               beat_idx == (t_unc[pend_entry] ? 0 : int'(t_offset[pend_entry][3:2])));
                end
                check_word(t_name[pend_entry], mem_word(word_addr(pend_entry)), rdata);
                pend_valid = 1'b0;
            end

            accept = valid && addr_ok;
            if (accept) begin
                if (pend_valid) begin
                    fail_run("a new request was accepted before the last one returned data");
                end
                if (last_acc >= 0) begin
                    check_bus_count(last_acc, bus_reqs - reqs_at_acc);
                    if (!t_req[last_acc]) begin
                        check_flag({t_name[next_entry], " back_to_back accept"}, 1'b1,
                                   cycle == acc_cycle + 1);
                    end
                end
                pend_valid  = 1'b1;
                pend_entry  = next_entry;
                acc_cycle   = cycle;
                last_acc    = next_entry;
                reqs_at_acc = bus_reqs;
                next_entry++;
            end

            if (rd_req && rd_rdy) begin
                if (last_acc < 0) begin
                    fail_run("rd_req rose before any request was accepted");
                end else if (!t_req[last_acc]) begin
                    fail_run({t_name[last_acc], " raised rd_req for a read that should hit"});
                end
                check_type({t_name[last_acc], " rd_type"}, t_type[last_acc], rd_type);
                check_addr({t_name[last_acc], " rd_addr"}, req_addr(last_acc), rd_addr);
                bus_reqs++;
                beat_line  = !t_unc[last_acc];
                beat_total = beat_line ? NUM_BANKS : 1;
                beat_base  = beat_line ? req_addr(last_acc) : word_addr(last_acc);
                beat_idx   = 0;
                rng        = xorshift32(rng);
                gap        = int'(rng % 3);
                bus_phase  = PH_BEATS;
            end else if (bus_phase == PH_IDLE && rd_req) begin
                rng       = xorshift32(rng);
                rdy_wait  = int'(rng % 4);
                bus_phase = PH_WAIT;
            end
            if (ret_valid) begin
                beat_idx++;
                if (ret_last) begin
                    bus_phase = PH_IDLE;
                end else begin
                    rng = xorshift32(rng);
                    gap = int'(rng % 3); // idle cycles before the next beat
                end
            end

            if (next_entry == NUM_TESTS && !pend_valid && bus_phase == PH_IDLE && !rd_req) begin
                tail++;
            end else begin
                tail = 0;
            end

            @(posedge clk);
            valid <= (next_entry < NUM_TESTS);
            if (next_entry < NUM_TESTS) begin
                index  <= t_index[next_entry];
                offset <= t_offset[next_entry];
            end
            if (accept) begin
                tag        <= t_tag[last_acc]; // tag and uncached flag trail the index
                uncache_en <= t_unc[last_acc];
            end
            rd_rdy    <= (bus_phase == PH_WAIT && rdy_wait == 0);
            ret_valid <= (bus_phase == PH_BEATS && gap == 0);
            ret_last  <= (bus_phase == PH_BEATS && gap == 0 && beat_idx == beat_total - 1);
            ret_data  <= mem_word(beat_base + addr_t'(beat_idx * 4));
            if (bus_phase == PH_WAIT && rdy_wait > 0) begin
                rdy_wait--;
            end
            if (bus_phase == PH_BEATS && gap > 0) begin
                gap--;
            end
        end

        check_bus_count(last_acc, bus_reqs - reqs_at_acc);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_top.f
rtl/icache_pkg.sv
rtl/icache_sram.sv
rtl/icache_lfsr.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
sim/icache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = icache_tb
FILELIST  = icache_top.f
LOG       = sim.log

.PHONY: sim clean

# the log decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
